// ==== include/riscv.svh ====
// RV32I base opcodes and funct3 codes only; no FENCE, SYSTEM or compressed encodings
`ifndef RISCV_SVH
`define RISCV_SVH

// Major opcodes
`define OPCODE_OP     7'b0110011
`define OPCODE_OPIMM  7'b0010011
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111

// funct3 for OP and OP-IMM
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// funct3 for LOAD and STORE
`define F3_B  3'b000
`define F3_H  3'b001
`define F3_W  3'b010
`define F3_BU 3'b100
`define F3_HU 3'b101

// funct3 for BRANCH
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

// ==== run.sh ====
#!/bin/sh
# Builds tb_rv_core with Verilator, runs it, and passes only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Test passed$'; then
    exit 0
fi
exit 1

// ==== source/alu.sv ====
// Single-cycle ALU for RV32I; shifts use only the low five bits of operand B
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  aluop_t          aluop,
    input  logic [XLEN-1:0] opr_a,
    input  logic [XLEN-1:0] opr_b,
    output logic [XLEN-1:0] result
);
    logic [4:0] shamt;

    assign shamt = opr_b[4:0];

    always_comb
    begin
        case (aluop)
            alu_add:    result = opr_a + opr_b;
            alu_sub:    result = opr_a - opr_b;
            alu_sll:    result = opr_a << shamt;
            alu_slt:    result = XLEN'($signed(opr_a) < $signed(opr_b));
            alu_sltu:   result = XLEN'(opr_a < opr_b);
            alu_xor:    result = opr_a ^ opr_b;
            alu_srl:    result = opr_a >> shamt;
            alu_sra:    result = $signed(opr_a) >>> shamt;
            alu_or:     result = opr_a | opr_b;
            alu_and:    result = opr_a & opr_b;
            // LUI, B carries the U-immediate
            alu_pass_b: result = opr_b;
            default:    result = '0;
        endcase
    end

endmodule: alu

// ==== source/cfu.sv ====
// Branch decision only; the target address comes from the ALU
`timescale 1ns/1ps

module cfu
    import core_pkg::*;
(
    input  cfuop_t          cfuop,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            redirect
);
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_data == rs2_data);
    assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_u = (rs1_data < rs2_data);

    always_comb
    begin
        case (cfuop)
            cfu_beq:            redirect = eq;
            cfu_bne:            redirect = !eq;
            cfu_blt:            redirect = lt_s;
            cfu_bge:            redirect = !lt_s;
            cfu_bltu:           redirect = lt_u;
            cfu_bgeu:           redirect = !lt_u;
            cfu_jal, cfu_jalr:  redirect = 1'b1;
            default:            redirect = 1'b0;
        endcase
    end

endmodule: cfu

// ==== source/core_pkg.sv ====
// Decode functions assume legal RV32I encodings; unknown fields fall back to add or none
`include "riscv.svh"

package core_pkg;

    localparam int XLEN = 32;

    typedef enum logic [3:0]
    {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } aluop_t;

    // Nine access kinds need four bits
    typedef enum logic [3:0]
    {
        lsu_none,
        lsu_lb,
        lsu_lh,
        lsu_lw,
        lsu_lbu,
        lsu_lhu,
        lsu_sb,
        lsu_sh,
        lsu_sw
    } lsuop_t;

    typedef enum logic [3:0]
    {
        cfu_none,
        cfu_beq,
        cfu_bne,
        cfu_blt,
        cfu_bge,
        cfu_bltu,
        cfu_bgeu,
        cfu_jal,
        cfu_jalr
    } cfuop_t;

    typedef enum logic [1:0]
    {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_t;

    // ##########################################################
    // Micro-operation decode

    function automatic aluop_t gen_aluop_f(
        input logic [6:0] opcode,
        input logic [6:0] funct7,
        input logic [2:0] funct3
    );
        aluop_t op;
        op = alu_add;
        if (opcode == `OPCODE_LUI)
        begin
            op = alu_pass_b;
        end
        else if (opcode == `OPCODE_OP || opcode == `OPCODE_OPIMM)
        begin
            case (funct3)
                // Bit 30 selects sub only for register-register ops
                `F3_ADD_SUB: op = (opcode == `OPCODE_OP && funct7[5]) ? alu_sub : alu_add;
                `F3_SLL:     op = alu_sll;
                `F3_SLT:     op = alu_slt;
                `F3_SLTU:    op = alu_sltu;
                `F3_XOR:     op = alu_xor;
                `F3_SRL_SRA: op = funct7[5] ? alu_sra : alu_srl;
                `F3_OR:      op = alu_or;
                default:     op = alu_and;
            endcase
        end
        return op;
    endfunction

    function automatic lsuop_t gen_lsuop_f(
        input logic [6:0] opcode,
        input logic [2:0] funct3
    );
        lsuop_t op;
        op = lsu_none;
        if (opcode == `OPCODE_LOAD)
        begin
            case (funct3)
                `F3_B:   op = lsu_lb;
                `F3_H:   op = lsu_lh;
                `F3_W:   op = lsu_lw;
                `F3_BU:  op = lsu_lbu;
                `F3_HU:  op = lsu_lhu;
                default: op = lsu_none;
            endcase
        end
        else if (opcode == `OPCODE_STORE)
        begin
            case (funct3)
                `F3_B:   op = lsu_sb;
                `F3_H:   op = lsu_sh;
                `F3_W:   op = lsu_sw;
                default: op = lsu_none;
            endcase
        end
        return op;
    endfunction

    function automatic cfuop_t gen_cfuop_f(
        input logic [6:0] opcode,
        input logic [2:0] funct3
    );
        cfuop_t op;
        op = cfu_none;
        case (opcode)
            `OPCODE_BRANCH:
            begin
                case (funct3)
                    `F3_BEQ:  op = cfu_beq;
                    `F3_BNE:  op = cfu_bne;
                    `F3_BLT:  op = cfu_blt;
                    `F3_BGE:  op = cfu_bge;
                    `F3_BLTU: op = cfu_bltu;
                    `F3_BGEU: op = cfu_bgeu;
                    default:  op = cfu_none;
                endcase
            end
            `OPCODE_JAL:  op = cfu_jal;
            `OPCODE_JALR: op = cfu_jalr;
            default:      op = cfu_none;
        endcase
        return op;
    endfunction

endpackage

// ==== source/ctrl_if.sv ====
// Decoded control bundle; all signals are combinational levels with no handshake
`timescale 1ns/1ps

interface ctrl_if
    import core_pkg::*;
();
    aluop_t  aluop;
    lsuop_t  lsuop;
    cfuop_t  cfuop;
    logic    rf_en;
    logic    dm_en;
    logic    opr_a_sel;
    logic    opr_b_sel;
    wb_sel_t wb_sel;

    modport decoder
    (
        output aluop, lsuop, cfuop, rf_en, dm_en, opr_a_sel, opr_b_sel, wb_sel
    );

    modport datapath
    (
        input aluop, lsuop, cfuop, rf_en, dm_en, opr_a_sel, opr_b_sel, wb_sel
    );

endinterface

// ==== source/ctrl_unit.sv ====
// Purely combinational decode; illegal opcodes are not flagged, they only drop all enables
`timescale 1ns/1ps
`include "riscv.svh"

module ctrl_unit
    import core_pkg::*;
(
    input  logic [6:0]     opcode,
    input  logic [6:0]     funct7,
    input  logic [2:0]     funct3,
    ctrl_if.decoder        ctrl
);
    // Micro-operations
    assign ctrl.aluop = gen_aluop_f(opcode, funct7, funct3);
    assign ctrl.lsuop = gen_lsuop_f(opcode, funct3);
    assign ctrl.cfuop = gen_cfuop_f(opcode, funct3);

    // Datapath selects, operand A is PC when set, operand B is the immediate when set
    always_comb
    begin
        ctrl.rf_en     = 1'b0;
        ctrl.dm_en     = 1'b0;
        ctrl.opr_a_sel = 1'b0;
        ctrl.opr_b_sel = 1'b0;
        ctrl.wb_sel    = wb_alu;
        case (opcode)
            `OPCODE_OP:
            begin
                ctrl.rf_en = 1'b1;
            end
            `OPCODE_OPIMM, `OPCODE_LUI:
            begin
                ctrl.rf_en     = 1'b1;
                ctrl.opr_b_sel = 1'b1;
            end
            `OPCODE_LOAD:
            begin
                ctrl.rf_en     = 1'b1;
                ctrl.opr_b_sel = 1'b1;
                ctrl.wb_sel    = wb_mem;
            end
            `OPCODE_STORE:
            begin
                ctrl.dm_en     = 1'b1;
                ctrl.opr_b_sel = 1'b1;
            end
            `OPCODE_BRANCH:
            begin
                // ALU forms the target, cfu compares the registers
                ctrl.opr_a_sel = 1'b1;
                ctrl.opr_b_sel = 1'b1;
            end
            `OPCODE_JAL:
            begin
                ctrl.rf_en     = 1'b1;
                ctrl.opr_a_sel = 1'b1;
                ctrl.opr_b_sel = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
            end
            `OPCODE_JALR:
            begin
                ctrl.rf_en     = 1'b1;
                ctrl.opr_b_sel = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
            end
            `OPCODE_AUIPC:
            begin
                ctrl.rf_en     = 1'b1;
                ctrl.opr_a_sel = 1'b1;
                ctrl.opr_b_sel = 1'b1;
            end
            default:
            begin
                ctrl.rf_en = 1'b0;
            end
        endcase
    end

endmodule: ctrl_unit

// ==== source/lsu.sv ====
// DMEM_WORDS must be a power of two; addresses wrap and misaligned low bits are used as is
`timescale 1ns/1ps

module lsu
    import core_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            arst_n,
    ctrl_if.datapath        ctrl,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [3:0]      byte_en;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] lane;

    assign word_idx = addr[AW+1:2];

    // ##########################################################
    // Store path

    always_comb
    begin
        byte_en    = 4'b0000;
        store_data = wdata;
        case (ctrl.lsuop)
            lsu_sb:
            begin
                byte_en    = 4'b0001 << addr[1:0];
                store_data = {4{wdata[7:0]}};
            end
            lsu_sh:
            begin
                byte_en    = 4'b0011 << {addr[1], 1'b0};
                store_data = {2{wdata[15:0]}};
            end
            lsu_sw:  byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (ctrl.dm_en)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (byte_en[b])
                begin
                    mem[word_idx][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
    end

    // ##########################################################
    // Load path

    assign word = mem[word_idx];
    // Addressed byte or half moved down to bit 0
    assign lane = word >> {addr[1:0], 3'b000};

    always_comb
    begin
        case (ctrl.lsuop)
            lsu_lb:  rdata = {{24{lane[7]}}, lane[7:0]};
            lsu_lh:  rdata = {{16{lane[15]}}, lane[15:0]};
            lsu_lw:  rdata = word;
            lsu_lbu: rdata = {24'b0, lane[7:0]};
            lsu_lhu: rdata = {16'b0, lane[15:0]};
            default: rdata = '0;
        endcase
    end

endmodule: lsu

// ==== source/reg_file.sv ====
// Flop-based register file, x0 hardwired to zero, no write-to-read bypass
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            we,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && rd != 5'd0)
        begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule: reg_file

// ==== source/rv_core.sv ====
// Single-cycle RV32I core without traps, CSRs or illegal-instruction detection; instr must match pc
`timescale 1ns/1ps
`include "riscv.svh"

module rv_core
    import core_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] pc,
    output logic            wb_en,
    output logic [4:0]      wb_rd,
    output logic [XLEN-1:0] wb_data
);
    logic [6:0]      opcode;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] pc_next;
    logic            redirect;

    ctrl_if ctrl ();

    assign opcode = instr[6:0];

    ctrl_unit u_ctrl_unit
    (
        .opcode (opcode),
        .funct7 (instr[31:25]),
        .funct3 (instr[14:12]),
        .ctrl   (ctrl)
    );

    reg_file u_reg_file
    (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (ctrl.rf_en),
        .rs1    (instr[19:15]),
        .rs2    (instr[24:20]),
        .rd     (instr[11:7]),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // ##########################################################
    // Immediate generation by instruction format

    always_comb
    begin
        case (opcode)
            `OPCODE_OPIMM, `OPCODE_LOAD, `OPCODE_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            `OPCODE_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `OPCODE_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            `OPCODE_LUI, `OPCODE_AUIPC:
                imm = {instr[31:12], 12'b0};
            `OPCODE_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    assign opr_a = ctrl.opr_a_sel ? pc : rs1_data;
    assign opr_b = ctrl.opr_b_sel ? imm : rs2_data;

    alu u_alu
    (
        .aluop  (ctrl.aluop),
        .opr_a  (opr_a),
        .opr_b  (opr_b),
        .result (alu_result)
    );

    cfu u_cfu
    (
        .cfuop    (ctrl.cfuop),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .redirect (redirect)
    );

    lsu #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_lsu (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .addr   (alu_result),
        .wdata  (rs2_data),
        .rdata  (mem_rdata)
    );

    // ##########################################################
    // Write-back and next PC

    assign pc_plus4 = pc + XLEN'(4);

    always_comb
    begin
        case (ctrl.wb_sel)
            wb_mem:      wb_data = mem_rdata;
            wb_pc_plus4: wb_data = pc_plus4;
            default:     wb_data = alu_result;
        endcase
    end

    assign wb_en = ctrl.rf_en;
    assign wb_rd = instr[11:7];

    // Only jalr can form an odd target
    assign target  = (opcode == `OPCODE_JALR) ? {alu_result[XLEN-1:1], 1'b0} : alu_result;
    assign pc_next = redirect ? target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc_next;
        end
    end

endmodule: rv_core

// ==== testbench/tb_rv_core.sv ====
// Random RV32I program checked against an ISA model; assumes DMEM_WORDS 256 and under 512 program words
`timescale 1ns/1ps
`include "riscv.svh"

module tb_rv_core;

    localparam int DMEM_WORDS = 256;
    localparam int MEM_BYTES  = 4 * DMEM_WORDS;
    localparam int PROG_WORDS = 96;
    localparam int TIMEOUT    = 2000;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] model_regs [32];
    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] model_pc;
    int          errors;
    int          timeouts;
    int          cycles;
    bit          running;
    bit          done;

    rv_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ##########################################################
    // Instruction encoders

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPCODE_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] upper, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {upper, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPCODE_JAL};
    endfunction

    // ##########################################################
    // Program generation

    function automatic logic [4:0] rand_reg();
        return 5'(1 + $urandom_range(6));
    endfunction

    // Aligned offset into the first 256 bytes of data memory
    function automatic logic [11:0] mem_offset(input logic [1:0] size);
        logic [11:0] off;
        off = 12'(4 * $urandom_range(63));
        if (size == 2'd0)
        begin
            off = off + 12'($urandom_range(3));
        end
        else if (size == 2'd1)
        begin
            off = off + 12'(2 * $urandom_range(1));
        end
        return off;
    endfunction

    function automatic logic [31:0] random_instr(input int idx);
        int          sel;
        int          k;
        int          t;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] ins;
        sel = int'($urandom_range(9));
        k   = 1 + int'($urandom_range(3));
        // Forward targets never pass the final self jump
        if (idx + k > PROG_WORDS - 1)
        begin
            k = PROG_WORDS - 1 - idx;
        end
        f3  = 3'($urandom_range(7));
        rd  = rand_reg();
        rs1 = rand_reg();
        rs2 = rand_reg();
        imm = 12'($urandom);
        f7  = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
        case (sel)
            0, 1:
            begin
                if (f3 != `F3_ADD_SUB && f3 != `F3_SRL_SRA)
                begin
                    f7 = 7'h00;
                end
                ins = r_type(f7, rs2, rs1, f3, rd, `OPCODE_OP);
            end
            2, 3:
            begin
                if (f3 == `F3_SLL)
                begin
                    imm = {7'h00, imm[4:0]};
                end
                else if (f3 == `F3_SRL_SRA)
                begin
                    imm = {f7, imm[4:0]};
                end
                ins = i_type(imm, rs1, f3, rd, `OPCODE_OPIMM);
            end
            4:
            begin
                f3  = 3'($urandom_range(2));
                ins = s_type(mem_offset(f3[1:0]), rs2, 5'd0, f3);
            end
            5:
            begin
                t   = int'($urandom_range(4));
                f3  = (t < 3) ? 3'(t) : 3'(t + 1);
                ins = i_type(mem_offset(f3[1:0]), 5'd0, f3, rd, `OPCODE_LOAD);
            end
            6:
            begin
                t   = int'($urandom_range(5));
                f3  = (t < 2) ? 3'(t) : 3'(t + 2);
                ins = b_type(13'(4 * k), rs2, rs1, f3);
            end
            7:
            begin
                ins = j_type(21'(4 * k), rd);
            end
            8:
            begin
                // Odd absolute target, bit 0 must be dropped
                ins = i_type(12'(4 * (idx + k) + 1), 5'd0, 3'd0, rd, `OPCODE_JALR);
            end
            default:
            begin
                ins = u_type(20'($urandom), rd,
                             ($urandom_range(1) == 1) ? `OPCODE_LUI : `OPCODE_AUIPC);
            end
        endcase
        return ins;
    endfunction

    task automatic build_program();
        prog[0]  = i_type(12'h9a5, 5'd0, `F3_ADD_SUB, 5'd1, `OPCODE_OPIMM);
        prog[1]  = u_type(20'h8f3c1, 5'd2, `OPCODE_LUI);
        prog[2]  = i_type(12'h2b6, 5'd2, `F3_ADD_SUB, 5'd2, `OPCODE_OPIMM);
        prog[3]  = s_type(12'd16, 5'd2, 5'd0, `F3_W);
        // Every load width and sign from the stored word
        prog[4]  = i_type(12'd19, 5'd0, `F3_B, 5'd3, `OPCODE_LOAD);
        prog[5]  = i_type(12'd19, 5'd0, `F3_BU, 5'd4, `OPCODE_LOAD);
        prog[6]  = i_type(12'd18, 5'd0, `F3_H, 5'd5, `OPCODE_LOAD);
        prog[7]  = i_type(12'd18, 5'd0, `F3_HU, 5'd6, `OPCODE_LOAD);
        prog[8]  = i_type(12'd16, 5'd0, `F3_W, 5'd7, `OPCODE_LOAD);
        // Write x0, then read it back through add
        prog[9]  = i_type(12'd5, 5'd1, `F3_ADD_SUB, 5'd0, `OPCODE_OPIMM);
        prog[10] = r_type(7'h00, 5'd0, 5'd0, `F3_ADD_SUB, 5'd3, `OPCODE_OP);
        for (int i = 11; i < PROG_WORDS - 1; i++)
        begin
            prog[i] = random_instr(i);
        end
        prog[PROG_WORDS-1] = j_type(21'd0, 5'd0);
    endtask

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < PROG_WORDS)
        begin
            return prog[idx];
        end
        return j_type(21'd0, 5'd0);
    endfunction

    function automatic string group_name(input logic [6:0] op);
        case (op)
            `OPCODE_OP:     return "OP";
            `OPCODE_OPIMM:  return "OP-IMM";
            `OPCODE_LOAD:   return "LOAD";
            `OPCODE_STORE:  return "STORE";
            `OPCODE_BRANCH: return "BRANCH";
            `OPCODE_JAL:    return "JAL";
            `OPCODE_JALR:   return "JALR";
            `OPCODE_LUI:    return "LUI";
            `OPCODE_AUIPC:  return "AUIPC";
            default:        return "UNKNOWN";
        endcase
    endfunction

    // ##########################################################
    // ISA reference model

    function automatic logic [31:0] compute_op(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            `F3_ADD_SUB: r = alt ? a - b : a + b;
            `F3_SLL:     r = a << b[4:0];
            `F3_SLT:     r = {31'b0, $signed(a) < $signed(b)};
            `F3_SLTU:    r = {31'b0, a < b};
            `F3_XOR:     r = a ^ b;
            `F3_SRL_SRA:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            `F3_OR:      r = a | b;
            default:     r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] model_step(ref logic [31:0] regs [32],
                                               ref logic [7:0] mem [MEM_BYTES],
                                               input logic [31:0] cur_pc,
                                               input logic [31:0] ins,
                                               output logic en,
                                               output logic [4:0] rd,
                                               output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] next;
        logic [2:0]  f3;
        logic        taken;
        int          nbytes;
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        f3     = ins[14:12];
        rd     = ins[11:7];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u  = {ins[31:12], 12'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nbytes = 1 << f3[1:0];
        en     = 1'b0;
        data   = '0;
        taken  = 1'b0;
        next   = cur_pc + 32'd4;
        case (ins[6:0])
            `OPCODE_OP:
            begin
                en   = 1'b1;
                data = compute_op(f3, ins[30], a, b);
            end
            `OPCODE_OPIMM:
            begin
                en   = 1'b1;
                data = compute_op(f3, ins[30] && f3 == `F3_SRL_SRA, a, imm_i);
            end
            `OPCODE_LOAD:
            begin
                en   = 1'b1;
                addr = a + imm_i;
                for (int k = 0; k < nbytes; k++)
                begin
                    data[8*k +: 8] = mem[int'((addr + 32'(k)) % 32'(MEM_BYTES))];
                end
                if (!f3[2] && nbytes == 1)
                    data = {{24{data[7]}}, data[7:0]};
                else if (!f3[2] && nbytes == 2)
                    data = {{16{data[15]}}, data[15:0]};
            end
            `OPCODE_STORE:
            begin
                addr = a + imm_s;
                for (int k = 0; k < nbytes; k++)
                begin
                    mem[int'((addr + 32'(k)) % 32'(MEM_BYTES))] = b[8*k +: 8];
                end
            end
            `OPCODE_BRANCH:
            begin
                case (f3)
                    `F3_BEQ:  taken = (a == b);
                    `F3_BNE:  taken = (a != b);
                    `F3_BLT:  taken = ($signed(a) < $signed(b));
                    `F3_BGE:  taken = !($signed(a) < $signed(b));
                    `F3_BLTU: taken = (a < b);
                    `F3_BGEU: taken = !(a < b);
                    default:  taken = 1'b0;
                endcase
                if (taken)
                    next = cur_pc + imm_b;
            end
            `OPCODE_JAL:
            begin
                en   = 1'b1;
                data = cur_pc + 32'd4;
                next = cur_pc + imm_j;
            end
            `OPCODE_JALR:
            begin
                en   = 1'b1;
                data = cur_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
            end
            `OPCODE_LUI:
            begin
                en   = 1'b1;
                data = imm_u;
            end
            `OPCODE_AUIPC:
            begin
                en   = 1'b1;
                data = cur_pc + imm_u;
            end
            default:
            begin
                en = 1'b0;
            end
        endcase
        if (en && rd != 5'd0)
            regs[rd] = data;
        return next;
    endfunction

    // ##########################################################
    // Stimulus and compare

    always @(posedge clk)
    begin
        instr <= program_word(model_pc);
    end

    always @(negedge clk)
    begin
        logic [31:0] ins;
        logic [31:0] next;
        logic        exp_en;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        string       name;
        if (running && !done)
        begin
            ins  = program_word(model_pc);
            name = group_name(ins[6:0]);
            assert (pc === model_pc)
            else
            begin
                errors++;
                $display("[ERROR] %s pc: expected %h actual %h", name, model_pc, pc);
            end
            next = model_step(model_regs, model_mem, model_pc, ins, exp_en, exp_rd, exp_data);
            assert (wb_en === exp_en)
            else
            begin
                errors++;
                $display("[ERROR] %s wb_en at pc %h: expected %b actual %b",
                         name, model_pc, exp_en, wb_en);
            end
            if (exp_en)
            begin
                assert (wb_rd === exp_rd)
                else
                begin
                    errors++;
                    $display("[ERROR] %s wb_rd at pc %h: expected %0d actual %0d",
                             name, model_pc, exp_rd, wb_rd);
                end
                assert (wb_data === exp_data)
                else
                begin
                    errors++;
                    $display("[ERROR] %s wb_data at pc %h: expected %h actual %h",
                             name, model_pc, exp_data, wb_data);
                end
            end
            // The final self jump ends the program
            if (model_pc == 32'(4 * (PROG_WORDS - 1)))
                done = 1'b1;
            model_pc = next;
        end
    end

    initial
    begin
        arst_n   = 1'b0;
        instr    = '0;
        model_pc = '0;
        errors   = 0;
        timeouts = 0;
        running  = 1'b0;
        done     = 1'b0;
        void'($urandom(32'he816f7a9));
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        for (int m = 0; m < MEM_BYTES; m++)
            model_mem[m] = '0;
        build_program();

        repeat (2) @(posedge clk);
        arst_n  <= 1'b1;
        running = 1'b1;

        cycles = 0;
        while (!done && cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (done)
        else
        begin
            timeouts++;
            $display("Timeout: the program did not reach its final jump in %0d cycles", TIMEOUT);
        end

        $display("Finished with %0d mismatches and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule: tb_rv_core

// ==== vlog.f ====
+incdir+include
source/core_pkg.sv
source/ctrl_if.sv
source/ctrl_unit.sv
source/reg_file.sv
source/alu.sv
source/cfu.sv
source/lsu.sv
source/rv_core.sv
testbench/tb_rv_core.sv
